// ==== list.f ====
+incdir+logic
logic/forth_pkg.sv
logic/byte_ram.sv
logic/word_finder.sv
logic/dict_search.sv
bench/dict_search_tb.sv

// ==== Makefile ====
# Verilator build and run for the dictionary search testbench

SIM      := verilator
TOP      := dict_search_tb
RTL_TOP  := dict_search
FILELIST := list.f
BUILD    := obj_dir
LOG      := sim.log
FLAGS    := --binary --timing -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall
PASS     := Test passed

SOURCES  := $(shell grep -v '^+' $(FILELIST)) logic/forth_config.svh

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS)$$" $(LOG)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bench/dict_search_tb.sv ====
`timescale 1ns/1ps
// directed searches over small dictionaries loaded through the host port
// dictionary and tib sit in separate RAM regions; names hold no space byte
`include "forth_config.svh"

module dict_search_tb;

    import forth_pkg::*;

    localparam int CLK_HALF     = 20;       // 40 ns period
    localparam int DRIVE_DLY    = 2;        // inputs change after the edge
    localparam int MAX_WORDS    = 8;
    localparam int MAX_NAME     = 6;        // longest name in any test
    localparam int N_SEARCH     = 24;       // upper bound on run_find calls
    localparam int LOAD_CYCLES  = 1500;     // host writes and reads rounded up
    localparam int WORD_CYCLES  = 4 + 2 * MAX_NAME;
    localparam int LIMIT_CYCLES = 2 * (N_SEARCH * (MAX_WORDS * WORD_CYCLES + 8) + LOAD_CYCLES);
    localparam logic [`FORTH_ASZ-1:0] DICT_BASE = 16'h0200;
    localparam logic [`FORTH_ASZ-1:0] TIB_ADDR  = 16'h8000;

    logic                  clk;
    logic                  rst;
    logic                  en;
    find_cmd               cmd;
    mem_req                host;
    logic [`FORTH_DSZ-1:0] rdata;
    logic                  bsy;
    find_result            result;

    // bench copy of the dictionary in oldest first order
    logic [`FORTH_ASZ-1:0] word_addr [MAX_WORDS];
    logic [`FORTH_DSZ-1:0] word_name [MAX_WORDS][MAX_NAME];
    int                    word_len  [MAX_WORDS];
    int                    word_cnt;
    logic [`FORTH_ASZ-1:0] latest;          // newest header used as ctx
    logic [`FORTH_ASZ-1:0] here;            // next free dictionary byte

    // staging text and tib copy
    logic [`FORTH_DSZ-1:0] txt [MAX_NAME];
    int                    txt_len;
    logic [`FORTH_DSZ-1:0] tib_text [MAX_NAME+1];   // text plus delimiter
    int                    tib_len;

    integer                seed;

    dict_search i_dict_search (
        .clk    (clk),
        .rst    (rst),
        .en     (en),
        .cmd    (cmd),
        .host   (host),
        .rdata  (rdata),
        .bsy    (bsy),
        .result (result)
    );

    always #CLK_HALF clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_byte(input string name, input logic [`FORTH_DSZ-1:0] exp,
                              input logic [`FORTH_DSZ-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("error: %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("error: %s expected %h got %h", name, exp, act));
        end
    endtask

    // pfa is meaningful only with hit set
    task automatic check_result(input string name, input find_result exp,
                                input find_result act, input bit check_pfa);
        if (act.hit !== exp.hit) begin
            stop_run($sformatf("error: %s.hit expected %h got %h", name, exp.hit, act.hit));
        end
        if (check_pfa && (act.pfa !== exp.pfa)) begin
            stop_run($sformatf("error: %s.pfa expected %h got %h", name, exp.pfa, act.pfa));
        end
    endtask

    task automatic host_write(input logic [`FORTH_ASZ-1:0] addr,
                              input logic [`FORTH_DSZ-1:0] data);
        host.we    = 1'b1;
        host.addr  = addr;
        host.wdata = data;
        @(posedge clk);                     // write lands here
        #DRIVE_DLY;
        host.we    = 1'b0;
    endtask

    task automatic host_read(input logic [`FORTH_ASZ-1:0] addr,
                             output logic [`FORTH_DSZ-1:0] data);
        host.we   = 1'b0;
        host.addr = addr;
        @(posedge clk);                     // registered read
        #DRIVE_DLY;
        data = rdata;
    endtask

    task automatic set_text(input string s);
        if (s.len() > MAX_NAME || s.len() == 0) begin
            stop_run($sformatf("text '%s' does not fit the name buffer", s));
        end
        txt_len = s.len();
        for (int i = 0; i < txt_len; i++) begin
            txt[i] = s[i];
        end
    endtask

    // draws 1 to MAX_NAME lower case letters and puts a digit first for a sure miss
    task automatic rand_text(input bit miss);
        logic [31:0] r;
        r = $random(seed);
        txt_len = 1 + int'(r[15:8] % 8'(MAX_NAME));
        for (int i = 0; i < txt_len; i++) begin
            r = $random(seed);
            txt[i] = 8'h61 + (r[7:0] % 8'd26);
        end
        if (miss) begin
            txt[0] = 8'h39;                 // '9' never starts a name
        end
    endtask

    task automatic new_dict();
        word_cnt = 0;
        here     = DICT_BASE;
        latest   = `FORTH_LINK_END;         // first word ends the chain
    endtask

    // writes link lo, link hi, length, name and 2 parameter bytes
    task automatic add_word();
        logic [`FORTH_ASZ-1:0] addr;
        logic [`FORTH_ASZ-1:0] ptr;
        if (word_cnt >= MAX_WORDS) begin
            stop_run("dictionary model is full");
        end
        addr = here;
        host_write(addr, latest[`FORTH_DSZ-1:0]);
        host_write(addr + 16'd1, latest[`FORTH_ASZ-1:`FORTH_DSZ]);
        host_write(addr + 16'd2, txt_len[`FORTH_DSZ-1:0]);
        ptr = addr + 16'd3;
        for (int i = 0; i < txt_len; i++) begin
            host_write(ptr, txt[i]);
            word_name[word_cnt][i] = txt[i];
            ptr = ptr + 16'd1;
        end
        for (int i = 0; i < 2; i++) begin
            host_write(ptr, ptr[15:8] ^ ptr[7:0] ^ 8'ha5);  // parameter field filler
            ptr = ptr + 16'd1;
        end
        word_addr[word_cnt] = addr;
        word_len[word_cnt]  = txt_len;
        word_cnt            = word_cnt + 1;
        latest              = addr;
        here                = ptr;
    endtask

    task automatic put_tib();
        for (int i = 0; i < txt_len; i++) begin
            host_write(TIB_ADDR + 16'(i), txt[i]);
            tib_text[i] = txt[i];
        end
        host_write(TIB_ADDR + 16'(txt_len), 8'h20);  // delimiter
        tib_text[txt_len] = 8'h20;
        tib_len = txt_len + 1;
    endtask

    // walks newest first and takes the first name equal to the tib prefix
    function automatic find_result model_find();
        find_result res;
        bit         found;
        bit         same;
        res   = '0;
        found = 1'b0;
        for (int w = word_cnt - 1; w >= 0; w--) begin
            same = 1'b1;
            for (int j = 0; j < word_len[w]; j++) begin
                if (j >= tib_len || word_name[w][j] != tib_text[j]) begin
                    same = 1'b0;
                end
            end
            if (same && !found) begin
                found   = 1'b1;
                res.hit = 1'b1;
                res.pfa = word_addr[w] + 16'd3 + 16'(word_len[w]);
            end
        end
        return res;
    endfunction

    task automatic run_find(input bit want_hit);
        find_result exp;
        find_result act;
        find_result held;
        exp = model_find();
        if (exp.hit != want_hit) begin
            stop_run("bench model result does not match the intent of the test");
        end
        cmd.ctx = latest;
        cmd.tib = TIB_ADDR;
        en      = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        if (bsy !== 1'b1) begin
            stop_run("bsy did not rise on the first edge after en went high");
        end
        while (bsy === 1'b1) begin          // watchdog bounds this
            @(posedge clk);
            #DRIVE_DLY;
        end
        act = result;
        check_result("result", exp, act, exp.hit);
        en       = 1'b0;
        held.hit = 1'b0;                    // hit clears with en low
        held.pfa = exp.pfa;
        repeat (3) begin
            @(posedge clk);
            #DRIVE_DLY;
            check_flag("bsy", 1'b0, bsy);
            check_result("result", held, result, exp.hit);
        end
    endtask

    task automatic readback_host_bytes();
        logic [`FORTH_ASZ-1:0] addrs [7];
        logic [`FORTH_DSZ-1:0] data;
        addrs = '{16'h0000, 16'h0001, 16'h00ff, 16'h1234, 16'h7ffe, 16'hfffe, 16'hffff};
        foreach (addrs[i]) begin
            host_write(addrs[i], addrs[i][15:8] ^ addrs[i][7:0] ^ 8'h3c);
        end
        foreach (addrs[i]) begin
            host_read(addrs[i], data);
            check_byte("rdata", addrs[i][15:8] ^ addrs[i][7:0] ^ 8'h3c, data);
        end
    endtask

    task automatic load_numbers();
        new_dict();
        set_text("ONE");
        add_word();
        set_text("TWO");
        add_word();
        set_text("THREE");
        add_word();
        set_text("FOUR");
        add_word();
        set_text("FIVE");
        add_word();                         // newest
    endtask

    task automatic find_newest_word();
        load_numbers();
        set_text("FIVE");
        put_tib();
        run_find(1'b1);
    endtask

    task automatic walk_to_oldest_word();
        load_numbers();
        set_text("ONE");                    // oldest word needs a full walk
        put_tib();
        run_find(1'b1);
    endtask

    task automatic search_missing_word();
        load_numbers();
        set_text("SIX");
        put_tib();
        run_find(1'b0);
    endtask

    task automatic skip_near_miss();
        new_dict();
        set_text("SWAP");
        add_word();
        set_text("+");
        add_word();
        set_text("DUP");
        add_word();
        set_text("SWAQ");
        add_word();
        set_text("SWAP");                   // skips SWAQ and finds older SWAP
        put_tib();
        run_find(1'b1);
        set_text("+");                      // one byte name
        put_tib();
        run_find(1'b1);
        set_text("DUPX");                   // DUP is a prefix of the tib word
        put_tib();
        run_find(1'b1);
        set_text("-");
        put_tib();
        run_find(1'b0);
    endtask

    task automatic repeat_random_searches();
        logic [31:0] r;
        int          idx;
        new_dict();
        for (int i = 0; i < MAX_WORDS; i++) begin
            rand_text(1'b0);
            add_word();
        end
        for (int n = 0; n < 12; n++) begin
            if (n % 4 == 3) begin
                rand_text(1'b1);            // sure miss
                put_tib();
                run_find(1'b0);
            end else begin
                r   = $random(seed);
                idx = int'(r[15:0]) % word_cnt;
                txt_len = word_len[idx];
                for (int j = 0; j < txt_len; j++) begin
                    txt[j] = word_name[idx][j];
                end
                put_tib();
                run_find(1'b1);
            end
        end
    endtask

    initial begin
        find_result rst_res;
        clk     = 1'b0;
        seed    = 32'he24f_27a0;
        rst     = 1'b1;
        en      = 1'b0;
        cmd     = '0;
        host    = '0;
        tib_len = 0;
        txt_len = 0;
        rst_res = '0;
        new_dict();
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        check_flag("bsy", 1'b0, bsy);
        check_result("result", rst_res, result, 1'b1);
        readback_host_bytes();
        find_newest_word();
        walk_to_oldest_word();
        search_missing_word();
        skip_near_miss();
        repeat_random_searches();
        $display("Test passed");
        $finish;
    end

    // bound from search count, per word cost and host loading
    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        stop_run($sformatf("timeout: tests did not finish within %0d clock cycles",
                           LIMIT_CYCLES));
    end

endmodule

// ==== logic/dict_search.sv ====
`timescale 1ns/1ps
// dictionary search top: finder and its byte RAM
// host port works only with en low; rdata follows the address by one cycle
`include "forth_config.svh"

module dict_search (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  en,       // low = host access, high = search
    input  forth_pkg::find_cmd    cmd,      // stable while en high
    input  forth_pkg::mem_req     host,
    output logic [`FORTH_DSZ-1:0] rdata,    // RAM read byte, also to host
    output logic                  bsy,      // falls when search completes
    output forth_pkg::find_result result
);

    import forth_pkg::*;

    mem_req ram_req;                        // finder to RAM

    word_finder i_word_finder (
        .clk    (clk),
        .rst    (rst),
        .en     (en),
        .cmd    (cmd),
        .host   (host),
        .rdata  (rdata),
        .req    (ram_req),
        .bsy    (bsy),
        .result (result)
    );

    byte_ram i_byte_ram (
        .clk   (clk),
        .req   (ram_req),
        .rdata (rdata)
    );

endmodule

// ==== logic/word_finder.sv ====
`timescale 1ns/1ps
// walks the dictionary newest first, prefix compare of each name against the tib
// cmd must stay stable while en is high; pfa is only meaningful with hit set
// after a search the FSM parks until en drops, so result holds
`include "forth_config.svh"

module word_finder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  en,       // level, high runs a search
    input  forth_pkg::find_cmd    cmd,
    input  forth_pkg::mem_req     host,     // honoured only while idle
    input  logic [`FORTH_DSZ-1:0] rdata,    // RAM read byte
    output forth_pkg::mem_req     req,      // RAM port
    output logic                  bsy,
    output forth_pkg::find_result result
);

    import forth_pkg::*;

    finder_state             state;         // current walk state
    finder_state             state_nxt;
    logic [`FORTH_ASZ-1:0]   name_ptr;      // header / name byte pointer
    logic [`FORTH_ASZ-1:0]   tib_ptr;       // input text pointer
    link_word                link;          // link of the word under test
    logic [`FORTH_DSZ-1:0]   prev_byte;     // read byte one cycle back
    find_result              res;           // hit and pfa registers

    logic                    bytes_eq;      // name byte vs tib byte
    logic                    name_done;     // last name byte compared
    logic                    chain_end;     // oldest word reached
    logic                    word_end;      // current word settled

    // compare terms, valid in st_cmp
    assign bytes_eq  = (prev_byte == rdata);    // prev holds name byte, rdata the tib byte
    assign name_done = (name_ptr == res.pfa);   // pointer already past the last byte
    assign chain_end = (link.addr == `FORTH_LINK_END);
    assign word_end  = !bytes_eq || name_done;

    assign result = res;

    // state register, en low forces idle
    always_ff @(posedge clk) begin
        if (rst || !en) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                state_nxt = en ? st_link_lo : st_idle;  // start on en
            end
            st_link_lo: begin
                // busy cleared means the search is over, park here
                state_nxt = bsy ? st_link_hi : st_link_lo;
            end
            st_link_hi: state_nxt = st_len;
            st_len:     state_nxt = st_nfa;
            st_nfa:     state_nxt = st_tib;
            st_tib:     state_nxt = st_cmp;
            st_cmp: begin
                state_nxt = word_end ? st_link_lo : st_tib;  // next word or next byte
            end
            default:    state_nxt = st_idle;
        endcase
    end

    // RAM port, host passes through while idle, reads only otherwise
    always_comb begin
        req = '0;
        if (state == st_idle) begin
            req    = host;
            req.we = host.we & ~en;         // no stray write as en rises
        end else if (state == st_tib) begin
            req.addr = tib_ptr;             // tib byte
        end else begin
            req.addr = name_ptr;            // header or name byte
        end
    end

    // control registers
    always_ff @(posedge clk) begin
        if (rst) begin
            bsy     <= 1'b0;
            res.hit <= 1'b0;
            res.pfa <= '0;
        end else if (!en) begin
            bsy     <= 1'b0;                // search stopped or ended
            res.hit <= 1'b0;                // pfa holds
        end else begin
            case (state)
                st_idle: begin
                    bsy <= 1'b1;            // first edge after en
                end
                st_nfa: begin
                    // rdata is the length byte, name_ptr the first name byte
                    res.pfa <= name_ptr + {{(`FORTH_ASZ-`FORTH_DSZ){1'b0}}, rdata};
                end
                st_cmp: begin
                    if (word_end && (bytes_eq || chain_end)) begin
                        bsy     <= 1'b0;    // match or chain exhausted
                        res.hit <= bytes_eq;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // pointers and link, no reset
    always_ff @(posedge clk) begin
        prev_byte <= rdata;                 // delay for the name/tib compare
        case (state)
            st_idle: begin
                name_ptr <= cmd.ctx;        // newest header
            end
            st_link_lo: begin
                name_ptr <= name_ptr + 1'b1;    // link high byte
            end
            st_link_hi: begin
                link.bytes.lo <= rdata;     // low byte arrives
                name_ptr      <= name_ptr + 1'b1;   // length byte
            end
            st_len: begin
                link.bytes.hi <= rdata;     // high byte arrives
                name_ptr      <= name_ptr + 1'b1;   // first name byte
            end
            st_nfa: begin
                tib_ptr <= cmd.tib;         // restart input text
            end
            st_tib: begin
                name_ptr <= name_ptr + 1'b1;    // next name byte
            end
            st_cmp: begin
                if (!word_end) begin
                    tib_ptr <= tib_ptr + 1'b1;  // next tib byte
                end else if (!bytes_eq && !chain_end) begin
                    name_ptr <= link.addr;  // follow link to older word
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== logic/byte_ram.sv ====
`timescale 1ns/1ps
// single-port byte RAM, one cycle read latency
// a write cycle leaves rdata unchanged; contents undefined until loaded
`include "forth_config.svh"

module byte_ram (
    input  logic                  clk,
    input  forth_pkg::mem_req     req,      // one request per cycle
    output logic [`FORTH_DSZ-1:0] rdata     // byte addressed last cycle
);

    logic [`FORTH_DSZ-1:0] mem [`FORTH_MEM_DEPTH];  // whole address space

    // write lands at the edge, read is registered
    always_ff @(posedge clk) begin
        if (req.we) begin
            mem[req.addr] <= req.wdata;     // host store
        end else begin
            rdata <= mem[req.addr];         // host or finder fetch
        end
    end

endmodule

// ==== logic/forth_pkg.sv ====
// types for the dictionary finder, sized by forth_config.svh
// link_word assumes little-endian link storage, low byte first in memory
`include "forth_config.svh"

package forth_pkg;

    // walk states, one per memory access slot
    typedef enum logic [2:0] {
        st_idle,                            // host owns the RAM
        st_link_lo,                         // fetch link low byte
        st_link_hi,                         // fetch link high byte
        st_len,                             // fetch name length
        st_nfa,                             // fetch first name byte
        st_tib,                             // fetch tib byte
        st_cmp                              // compare, fetch next name byte
    } finder_state;

    typedef struct packed {
        logic                  we;          // 1 = write
        logic [`FORTH_ASZ-1:0] addr;
        logic [`FORTH_DSZ-1:0] wdata;
    } mem_req;

    typedef struct packed {
        logic [`FORTH_ASZ-1:0] ctx;         // newest word header
        logic [`FORTH_ASZ-1:0] tib;         // first input byte
    } find_cmd;

    typedef struct packed {
        logic                  hit;
        logic [`FORTH_ASZ-1:0] pfa;         // just past last name byte
    } find_result;

    typedef struct packed {
        logic [`FORTH_DSZ-1:0] hi;
        logic [`FORTH_DSZ-1:0] lo;
    } link_bytes;

    // same 16 bits, filled bytewise, read as next header address
    typedef union packed {
        link_bytes             bytes;
        logic [`FORTH_ASZ-1:0] addr;
    } link_word;

endpackage

// ==== logic/forth_config.svh ====
// sizes shared by RTL and bench
// a link field is two data bytes, so FORTH_ASZ must be twice FORTH_DSZ
`ifndef FORTH_CONFIG_SVH
`define FORTH_CONFIG_SVH

`define FORTH_ASZ       16          // byte address width, one link word
`define FORTH_DSZ       8           // byte-wide data path
`define FORTH_MEM_DEPTH 65536       // full 64K byte space
`define FORTH_LINK_END  16'hffff    // link of the oldest word

`endif
